// File: design/usb_loop_pkg.sv
package usb_loop_pkg;

  // Loop FIFO geometry, 8 data bits plus the packet-end flag per entry
  localparam int FIFO_ABITS = 11;
  localparam int FIFO_WIDTH = 9;
  localparam int LEVEL_BITS = FIFO_ABITS + 1;

  localparam logic [LEVEL_BITS-1:0] FIFO_DEPTH = LEVEL_BITS'(2 ** FIFO_ABITS);

  // Endpoint ready thresholds, compared against the FIFO level
  localparam logic [LEVEL_BITS-1:0] IN_READY_MIN = LEVEL_BITS'(4);
  localparam logic [LEVEL_BITS-1:0] OUT_READY_MAX = LEVEL_BITS'(1024);

  // SOF frame counter and the bits that pace the blink LED
  localparam int SOF_COUNT_BITS = 24;
  localparam int BLINK_BIT = 12;
  localparam int FAST_BLINK_LO = 10;
  localparam int FAST_BLINK_HI = 11;

endpackage

// File: design/bulk_endpoint.sv
module bulk_endpoint (
  input  logic clock,
  input  logic usb_reset,
  input  logic configured_i,
  input  logic blk_cycle_i,

  // Bulk OUT bytes from the host
  input  logic s_tvalid_i,
  input  logic s_tlast_i,
  input  logic [7:0] s_tdata_i,
  output logic s_tready_o,

  // Bulk IN bytes back to the host
  output logic m_tvalid_o,
  output logic m_tlast_o,
  output logic [7:0] m_tdata_o,
  input  logic m_tready_i,

  // Loop FIFO write and read sides
  output logic wr_valid_o,
  output logic [usb_loop_pkg::FIFO_WIDTH-1:0] wr_data_o,
  input  logic wr_ready_i,
  input  logic rd_valid_i,
  input  logic [usb_loop_pkg::FIFO_WIDTH-1:0] rd_data_i,
  output logic rd_ready_o,
  input  logic [usb_loop_pkg::LEVEL_BITS-1:0] level_i,

  output logic blk_in_ready_o,
  output logic blk_out_ready_o
);

  // Data only moves inside a bulk transaction
  assign wr_valid_o = s_tvalid_i & blk_cycle_i;
  assign s_tready_o = wr_ready_i & blk_cycle_i;
  assign wr_data_o  = {s_tlast_i, s_tdata_i};

  assign m_tvalid_o = rd_valid_i & blk_cycle_i;
  assign rd_ready_o = m_tready_i & blk_cycle_i;
  assign {m_tlast_o, m_tdata_o} = rd_data_i;

  // IN is ready once a few bytes are queued, OUT while there is room left
  always_ff @(posedge clock) begin
    if (usb_reset) begin
      blk_in_ready_o  <= 1'b0;
      blk_out_ready_o <= 1'b0;
    end else begin
      blk_in_ready_o  <= configured_i && (level_i > usb_loop_pkg::IN_READY_MIN);
      blk_out_ready_o <= configured_i && (level_i < usb_loop_pkg::OUT_READY_MAX);
    end
  end

endmodule

// File: design/loop_fifo.sv
module loop_fifo (
  input  logic clock,
  input  logic usb_reset,

  input  logic wr_valid_i,
  input  logic [usb_loop_pkg::FIFO_WIDTH-1:0] wr_data_i,
  output logic wr_ready_o,

  output logic rd_valid_o,
  output logic [usb_loop_pkg::FIFO_WIDTH-1:0] rd_data_o,
  input  logic rd_ready_i,

  output logic [usb_loop_pkg::LEVEL_BITS-1:0] level_o
);

  logic [usb_loop_pkg::FIFO_WIDTH-1:0] mem [2 ** usb_loop_pkg::FIFO_ABITS];

  // One extra pointer bit tells a full memory from an empty one
  logic [usb_loop_pkg::LEVEL_BITS-1:0] wr_ptr_q;
  logic [usb_loop_pkg::LEVEL_BITS-1:0] rd_ptr_q;
  logic [usb_loop_pkg::LEVEL_BITS-1:0] level_q;

  logic [usb_loop_pkg::FIFO_WIDTH-1:0] ram_data_q;
  logic ram_valid_q;
  logic [usb_loop_pkg::FIFO_WIDTH-1:0] out_data_q;
  logic out_valid_q;

  logic wr_fire;
  logic rd_fire;
  logic mem_empty;
  logic out_load;
  logic ram_load;

  assign wr_ready_o = level_q < usb_loop_pkg::FIFO_DEPTH;
  assign wr_fire    = wr_valid_i & wr_ready_o;
  assign rd_fire    = out_valid_q & rd_ready_i;
  assign mem_empty  = wr_ptr_q == rd_ptr_q;

  // Advance the read pipeline whenever the next stage has room
  assign out_load = ram_valid_q & (~out_valid_q | rd_ready_i);
  assign ram_load = ~mem_empty & (~ram_valid_q | out_load);

  always_ff @(posedge clock) begin
    if (wr_fire) begin
      mem[wr_ptr_q[usb_loop_pkg::FIFO_ABITS-1:0]] <= wr_data_i;
    end
  end

  // Block RAM read port
  always_ff @(posedge clock) begin
    if (ram_load) begin
      ram_data_q <= mem[rd_ptr_q[usb_loop_pkg::FIFO_ABITS-1:0]];
    end
  end

  always_ff @(posedge clock) begin
    if (out_load) begin
      out_data_q <= ram_data_q;
    end
  end

  always_ff @(posedge clock) begin
    if (usb_reset) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      ram_valid_q <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (ram_load) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end

      if (ram_load) begin
        ram_valid_q <= 1'b1;
      end else if (out_load) begin
        ram_valid_q <= 1'b0;
      end

      if (out_load) begin
        out_valid_q <= 1'b1;
      end else if (rd_ready_i) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  // Level covers memory plus both pipeline registers
  always_ff @(posedge clock) begin
    if (usb_reset) begin
      level_q <= '0;
    end else begin
      case ({wr_fire, rd_fire})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  assign rd_valid_o = out_valid_q;
  assign rd_data_o  = out_data_q;
  assign level_o    = level_q;

endmodule

// File: design/link_status.sv
module link_status (
  input  logic clock,
  input  logic usb_reset,
  input  logic configured_i,
  input  logic sof_i,
  input  logic crc_error_i,
  input  logic timeout_i,
  output logic [3:0] leds_o
);

  logic sof_q;
  logic sof_rise;
  logic [usb_loop_pkg::SOF_COUNT_BITS-1:0] sof_count_q;
  logic crc_latch_q;
  logic timeout_latch_q;
  logic blink;

  assign sof_rise = sof_i & ~sof_q;

  // Frame counter paces the blink LED
  always_ff @(posedge clock) begin
    if (usb_reset) begin
      sof_q       <= 1'b0;
      sof_count_q <= '0;
    end else begin
      sof_q <= sof_i;
      if (sof_rise) begin
        sof_count_q <= sof_count_q + 1'b1;
      end
    end
  end

  // Error strobes stick until the next reset
  always_ff @(posedge clock) begin
    if (usb_reset) begin
      crc_latch_q     <= 1'b0;
      timeout_latch_q <= 1'b0;
    end else begin
      if (crc_error_i) begin
        crc_latch_q <= 1'b1;
      end
      if (timeout_i) begin
        timeout_latch_q <= 1'b1;
      end
    end
  end

  // Short flashes once a CRC error has been seen
  assign blink = crc_latch_q ?
      sof_count_q[usb_loop_pkg::FAST_BLINK_LO] & sof_count_q[usb_loop_pkg::FAST_BLINK_HI] :
      sof_count_q[usb_loop_pkg::BLINK_BIT];

  // LEDs are active low
  assign leds_o = ~{blink, timeout_latch_q, crc_latch_q, configured_i};

endmodule

// File: design/usb_bulk_loopback.sv
module usb_bulk_loopback (
  input  logic clock,
  input  logic usb_reset,

  // Transaction status from the USB core
  input  logic configured_i,
  input  logic blk_cycle_i,
  input  logic sof_i,
  input  logic crc_error_i,
  input  logic timeout_i,

  input  logic s_tvalid_i,
  input  logic s_tlast_i,
  input  logic [7:0] s_tdata_i,
  output logic s_tready_o,

  output logic m_tvalid_o,
  output logic m_tlast_o,
  output logic [7:0] m_tdata_o,
  input  logic m_tready_i,

  output logic blk_in_ready_o,
  output logic blk_out_ready_o,
  output logic [3:0] leds_o
);

  logic wr_valid;
  logic wr_ready;
  logic [usb_loop_pkg::FIFO_WIDTH-1:0] wr_data;
  logic rd_valid;
  logic rd_ready;
  logic [usb_loop_pkg::FIFO_WIDTH-1:0] rd_data;
  logic [usb_loop_pkg::LEVEL_BITS-1:0] level;

  bulk_endpoint u_endpoint (
    .clock          (clock),
    .usb_reset      (usb_reset),
    .configured_i   (configured_i),
    .blk_cycle_i    (blk_cycle_i),
    .s_tvalid_i     (s_tvalid_i),
    .s_tlast_i      (s_tlast_i),
    .s_tdata_i      (s_tdata_i),
    .s_tready_o     (s_tready_o),
    .m_tvalid_o     (m_tvalid_o),
    .m_tlast_o      (m_tlast_o),
    .m_tdata_o      (m_tdata_o),
    .m_tready_i     (m_tready_i),
    .wr_valid_o     (wr_valid),
    .wr_data_o      (wr_data),
    .wr_ready_i     (wr_ready),
    .rd_valid_i     (rd_valid),
    .rd_data_i      (rd_data),
    .rd_ready_o     (rd_ready),
    .level_i        (level),
    .blk_in_ready_o (blk_in_ready_o),
    .blk_out_ready_o(blk_out_ready_o)
  );

  // OUT bytes come straight back as IN bytes
  loop_fifo u_fifo (
    .clock     (clock),
    .usb_reset (usb_reset),
    .wr_valid_i(wr_valid),
    .wr_data_i (wr_data),
    .wr_ready_o(wr_ready),
    .rd_valid_o(rd_valid),
    .rd_data_o (rd_data),
    .rd_ready_i(rd_ready),
    .level_o   (level)
  );

  link_status u_status (
    .clock       (clock),
    .usb_reset   (usb_reset),
    .configured_i(configured_i),
    .sof_i       (sof_i),
    .crc_error_i (crc_error_i),
    .timeout_i   (timeout_i),
    .leds_o      (leds_o)
  );

endmodule

// File: tb/usb_bulk_loopback_props.sv
module usb_bulk_loopback_props (
  input logic clock,
  input logic usb_reset,
  input logic blk_cycle_i,
  input logic s_tready_i,
  input logic m_tvalid_i,
  input logic m_tlast_i,
  input logic [7:0] m_tdata_i,
  input logic m_tready_i,
  input logic in_ready_i,
  input logic out_ready_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // IN word holds until the host takes it
  assert property (@(posedge clock) disable iff (usb_reset)
      m_tvalid_i && !m_tready_i |=> $stable(m_tdata_i) && $stable(m_tlast_i))
    else $error("IN data or last changed while stalled");

  // Both streams are closed outside a bulk transaction
  assert property (@(posedge clock) !blk_cycle_i |-> !s_tready_i && !m_tvalid_i)
    else $error("stream open while blk_cycle_i is low");

  assert property (@(posedge clock) usb_reset |=> !in_ready_i && !out_ready_i)
    else $error("ready flags not cleared by reset");

endmodule

bind usb_bulk_loopback usb_bulk_loopback_props u_props (
  .clock      (clock),
  .usb_reset  (usb_reset),
  .blk_cycle_i(blk_cycle_i),
  .s_tready_i (s_tready_o),
  .m_tvalid_i (m_tvalid_o),
  .m_tlast_i  (m_tlast_o),
  .m_tdata_i  (m_tdata_o),
  .m_tready_i (m_tready_i),
  .in_ready_i (blk_in_ready_o),
  .out_ready_i(blk_out_ready_o)
);

// File: tb/usb_bulk_loopback_tb.sv
module usb_bulk_loopback_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_PKTS = 5;
  localparam int CYCLE_LIMIT = 20000;

  logic clock = 1'b0;
  logic usb_reset;
  logic configured_i;
  logic blk_cycle_i;
  logic sof_i;
  logic crc_error_i;
  logic timeout_i;
  logic s_tvalid_i;
  logic s_tlast_i;
  logic [7:0] s_tdata_i;
  logic s_tready_o;
  logic m_tvalid_o;
  logic m_tlast_o;
  logic [7:0] m_tdata_o;
  logic m_tready_i;
  logic blk_in_ready_o;
  logic blk_out_ready_o;
  logic [3:0] leds_o;

  // Packet table of length, alternating bulk cycle, IN stall mode and status event
  // Stall mode 0 never stalls, 1 stalls at random, 2 never reads
  // Event 1 is a CRC error strobe, 2 a timeout strobe
  int pkt_len [NUM_PKTS] = '{1, 16, 64, 37, 200};
  bit pkt_alt [NUM_PKTS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
  int pkt_stall [NUM_PKTS] = '{0, 1, 1, 0, 1};
  int pkt_event [NUM_PKTS] = '{0, 0, 1, 2, 0};

  // Words are {last, data}
  logic [8:0] tx_q[$];
  logic [8:0] exp_q[$];
  int errors = 0;
  int timeouts = 0;
  int sof_count = 0;
  bit crc_seen = 1'b0;
  bit timeout_seen = 1'b0;

  usb_bulk_loopback dut0 (.*);

  always #4 clock = ~clock;

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("FAIL at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic apply_reset();
    usb_reset = 1'b1;
    repeat (10) @(negedge clock);
    usb_reset = 1'b0;
    sof_count = 0;
    crc_seen = 1'b0;
    timeout_seen = 1'b0;
  endtask

  task automatic check_idle_after_reset();
    if (m_tvalid_o !== 1'b0) report_mismatch("m_tvalid_o", 0, 32'(m_tvalid_o));
    if (s_tready_o !== 1'b0) report_mismatch("s_tready_o", 0, 32'(s_tready_o));
    if (blk_in_ready_o !== 1'b0) report_mismatch("blk_in_ready_o", 0, 32'(blk_in_ready_o));
    if (blk_out_ready_o !== 1'b0) report_mismatch("blk_out_ready_o", 0, 32'(blk_out_ready_o));
    // Only the configured LED is lit
    if (leds_o !== 4'b1110) report_mismatch("leds_o", 32'(4'b1110), 32'(leds_o));
  endtask

  // Ready flags trail the level by one register stage
  task automatic settle();
    repeat (3) @(negedge clock);
  endtask

  task automatic make_packet(input int len);
    logic [8:0] word;
    for (int i = 0; i < len; i++) begin
      word = {(i == len - 1), 8'($urandom)};
      tx_q.push_back(word);
      exp_q.push_back(word);
    end
  endtask

  // Host models for both streams make one decision per cycle before the rising edge
  task automatic transfer(input int n_send, input int n_recv, input bit alt, input int stall);
    int sent;
    int recvd;
    int cycles;
    logic [8:0] expected;
    sent = 0;
    recvd = 0;
    cycles = 0;
    while ((sent < n_send || recvd < n_recv) && cycles < CYCLE_LIMIT) begin
      blk_cycle_i = alt ? cycles[0] : 1'b1;
      m_tready_i = (stall == 0) ? 1'b1 : (stall == 1) ? 1'($urandom % 2) : 1'b0;
      s_tvalid_i = sent < n_send;
      if (sent < n_send) begin
        {s_tlast_i, s_tdata_i} = tx_q[0];
      end
      #1;
      if (!blk_cycle_i && (s_tready_o || m_tvalid_o)) begin
        $display("ERROR at %0t: stream handshake open while blk_cycle_i is low", $time);
        errors++;
      end
      if (s_tvalid_i && s_tready_o) begin
        void'(tx_q.pop_front());
        sent++;
      end
      if (m_tvalid_o && m_tready_i) begin
        if (exp_q.size() == 0) begin
          $display("ERROR at %0t: IN byte returned with nothing left to expect", $time);
          errors++;
        end else begin
          expected = exp_q.pop_front();
          if (m_tdata_o !== expected[7:0])
            report_mismatch("m_tdata_o", 32'(expected[7:0]), 32'(m_tdata_o));
          if (m_tlast_o !== expected[8])
            report_mismatch("m_tlast_o", 32'(expected[8]), 32'(m_tlast_o));
        end
        recvd++;
      end
      cycles++;
      @(negedge clock);
    end
    if (sent < n_send || recvd < n_recv) begin
      $display("ERROR at %0t: transfer stuck, %0d of %0d sent, %0d of %0d received",
               $time, sent, n_send, recvd, n_recv);
      timeouts++;
    end
    s_tvalid_i = 1'b0;
    m_tready_i = 1'b0;
    blk_cycle_i = 1'b0;
  endtask

  task automatic pulse_event(input int ev);
    crc_error_i = (ev == 1);
    timeout_i = (ev == 2);
    if (ev == 1) crc_seen = 1'b1;
    if (ev == 2) timeout_seen = 1'b1;
    @(negedge clock);
    crc_error_i = 1'b0;
    timeout_i = 1'b0;
    @(negedge clock);
  endtask

  task automatic check_status_leds();
    logic [2:0] expected;
    expected = {~timeout_seen, ~crc_seen, ~configured_i};
    if (leds_o[2:0] !== expected) report_mismatch("leds_o[2:0]", 32'(expected), 32'(leds_o[2:0]));
  endtask

  // Slow blink on frame bit 12 and short flashes on bits 10 and 11 after a CRC error
  task automatic sof_pulses(input int n);
    logic expected;
    for (int i = 0; i < n; i++) begin
      sof_i = 1'b1;
      @(negedge clock);
      sof_i = 1'b0;
      @(negedge clock);
      sof_count++;
      expected = crc_seen ? ~(sof_count[10] & sof_count[11]) : ~sof_count[12];
      if (leds_o[3] !== expected) report_mismatch("leds_o[3]", 32'(expected), 32'(leds_o[3]));
    end
  endtask

  initial begin
    void'($urandom(3));
    usb_reset = 1'b1;
    configured_i = 1'b1;
    blk_cycle_i = 1'b0;
    sof_i = 1'b0;
    crc_error_i = 1'b0;
    timeout_i = 1'b0;
    s_tvalid_i = 1'b0;
    s_tlast_i = 1'b0;
    s_tdata_i = 8'h00;
    m_tready_i = 1'b0;
    apply_reset();
    check_idle_after_reset();

    settle();
    if (blk_out_ready_o !== 1'b1) report_mismatch("blk_out_ready_o", 1, 32'(blk_out_ready_o));
    if (blk_in_ready_o !== 1'b0) report_mismatch("blk_in_ready_o", 0, 32'(blk_in_ready_o));

    // Fill past the OUT threshold with the IN side closed, then drain
    make_packet(1100);
    transfer(1100, 0, 1'b0, 2);
    settle();
    if (blk_out_ready_o !== 1'b0) report_mismatch("blk_out_ready_o", 0, 32'(blk_out_ready_o));
    if (blk_in_ready_o !== 1'b1) report_mismatch("blk_in_ready_o", 1, 32'(blk_in_ready_o));
    transfer(0, 1100, 1'b0, 0);
    settle();
    if (blk_out_ready_o !== 1'b1) report_mismatch("blk_out_ready_o", 1, 32'(blk_out_ready_o));
    if (blk_in_ready_o !== 1'b0) report_mismatch("blk_in_ready_o", 0, 32'(blk_in_ready_o));

    sof_pulses(4096);

    for (int p = 0; p < NUM_PKTS; p++) begin
      make_packet(pkt_len[p]);
      transfer(pkt_len[p], pkt_len[p], pkt_alt[p], pkt_stall[p]);
      pulse_event(pkt_event[p]);
      check_status_leds();
    end
    if (exp_q.size() != 0) begin
      $display("ERROR: %0d IN bytes never came back", exp_q.size());
      errors++;
    end

    sof_pulses(4096);

    // An unconfigured device reports no room and leaves the configured LED dark
    configured_i = 1'b0;
    settle();
    if (blk_out_ready_o !== 1'b0) report_mismatch("blk_out_ready_o", 0, 32'(blk_out_ready_o));
    check_status_leds();
    configured_i = 1'b1;

    apply_reset();
    check_idle_after_reset();

    $display("errors %0d, timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: src.f
design/usb_loop_pkg.sv
design/bulk_endpoint.sv
design/loop_fifo.sv
design/link_status.sv
design/usb_bulk_loopback.sv
tb/usb_bulk_loopback_props.sv
tb/usb_bulk_loopback_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module usb_bulk_loopback_tb \
  -f src.f \
  --Mdir build/obj_dir \
  -o sim

output=$(./build/obj_dir/sim)
echo "$output"
if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1
